// ==== aurora_frame_cfg.svh ====
`ifndef AURORA_FRAME_CFG_SVH
`define AURORA_FRAME_CFG_SVH

// Width of one stream beat and of one register word
`define AF_DATA_W 32

// Frame counters are read back as two register words
`define AF_CNTR_W 64

// Byte address into the register block, word index in bits 5..2
`define AF_ADDR_W 6

`endif

// ==== aurora_frame_pkg.sv ====
`include "aurora_frame_cfg.svh"

package aurora_frame_pkg;

   typedef logic [`AF_DATA_W-1:0] word_t;   // Stream beat or bus word
   typedef logic [`AF_CNTR_W-1:0] cntr_t;   // Frame counter

   // Transmit framer, data beats or the trailing sequence word
   typedef enum logic {
      TX_DATA = 1'b0,
      TX_SEQ  = 1'b1
   } tx_state_t;

   // Receive deframer holding register
   typedef enum logic {
      RX_EMPTY = 1'b0,
      RX_HELD  = 1'b1
   } rx_state_t;

   // Register word index
   typedef enum logic [3:0] {
      REG_STAT       = 4'd0,   // Sequence error count
      REG_CTRL       = 4'd1,
      REG_CNTR_IN_L  = 4'd2,
      REG_CNTR_IN_H  = 4'd3,
      REG_CNTR_OUT_H = 4'd6,
      REG_CNTR_OUT_L = 4'd7
   } reg_addr_t;

endpackage

// ==== seq_append.sv ====
`timescale 1ns/1ps

module seq_append
   import aurora_frame_pkg::*;
(
   input  logic  usr_clk,
   input  logic  S_AXI_ARESETN,

   // User transmit stream
   input  logic  s_tx_valid,
   input  word_t s_tx_data,
   input  logic  s_tx_last,
   output logic  s_tx_ready,

   // Link transmit stream
   output logic  link_tx_valid,
   output word_t link_tx_data,
   output logic  link_tx_last,
   input  logic  link_tx_ready,

   input  logic  cntr_clr,
   output cntr_t cntr_out
);

   tx_state_t state;
   word_t     seq_num;   // Sequence word of the frame in flight
   logic      data_xfer;
   logic      seq_xfer;

   // Data beats pass straight through, the sequence word is inserted after them
   always_comb begin
      if (state == TX_SEQ) begin
         link_tx_valid = 1'b1;
         link_tx_data  = seq_num;
         link_tx_last  = 1'b1;
         s_tx_ready    = 1'b0;   // User stalled during the inserted word
      end else begin
         link_tx_valid = s_tx_valid;
         link_tx_data  = s_tx_data;
         link_tx_last  = 1'b0;   // Last moves onto the sequence word
         s_tx_ready    = link_tx_ready;
      end
   end

   assign data_xfer = (state == TX_DATA) && s_tx_valid && link_tx_ready;
   assign seq_xfer  = (state == TX_SEQ) && link_tx_ready;

   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         state   <= TX_DATA;
         seq_num <= '0;
      end else begin
         case (state)
            TX_DATA: begin
               if (data_xfer && s_tx_last) begin
                  state <= TX_SEQ;
               end
            end
            TX_SEQ: begin
               if (seq_xfer) begin
                  state   <= TX_DATA;
                  seq_num <= seq_num + 1'b1;   // Next frame number
               end
            end
            default: state <= TX_DATA;
         endcase
      end
   end

   // Frames sent, counted when the sequence word leaves
   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         cntr_out <= '0;
      end else if (cntr_clr) begin
         cntr_out <= '0;
      end else if (seq_xfer) begin
         cntr_out <= cntr_out + 1'b1;
      end
   end

   // Offered link beat must not change until the link takes it
   a_link_hold: assert property (
      @(posedge usr_clk) disable iff (!S_AXI_ARESETN)
      (link_tx_valid && !link_tx_ready) |=> (link_tx_valid && $stable(link_tx_data))
   );

endmodule

// ==== seq_strip.sv ====
`timescale 1ns/1ps

module seq_strip
   import aurora_frame_pkg::*;
(
   input  logic  usr_clk,
   input  logic  S_AXI_ARESETN,

   // Link receive stream, no back-pressure
   input  logic  link_rx_valid,
   input  word_t link_rx_data,
   input  logic  link_rx_last,

   // User receive stream
   output logic  m_rx_valid,
   output word_t m_rx_data,
   output logic  m_rx_last,

   input  logic  strip_en,
   input  logic  cntr_clr,
   output cntr_t cntr_in,
   output word_t seq_err_cnt
);

   rx_state_t state;
   word_t     hold_data;   // Beat waiting to see if it is the last data beat
   word_t     seq_expect;
   logic      seq_beat;

   // Trailing word of every frame carries the sequence number
   assign seq_beat = link_rx_valid && link_rx_last;

   // Output strobes, one cycle after the arriving beat
   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         state      <= RX_EMPTY;
         m_rx_valid <= 1'b0;
         m_rx_last  <= 1'b0;
      end else begin
         m_rx_valid <= 1'b0;
         m_rx_last  <= 1'b0;
         if (link_rx_valid) begin
            if (!strip_en) begin
               m_rx_valid <= 1'b1;   // Pass-through
               m_rx_last  <= link_rx_last;
            end else if (link_rx_last) begin
               // Sequence word dropped, held beat closes the frame
               m_rx_valid <= (state == RX_HELD);
               m_rx_last  <= (state == RX_HELD);
               state      <= RX_EMPTY;
            end else begin
               m_rx_valid <= (state == RX_HELD);
               state      <= RX_HELD;
            end
         end
      end
   end

   always_ff @(posedge usr_clk) begin
      if (link_rx_valid) begin
         if (!strip_en) begin
            m_rx_data <= link_rx_data;
         end else begin
            m_rx_data <= hold_data;
            if (!link_rx_last) begin
               hold_data <= link_rx_data;
            end
         end
      end
   end

   // Continuity check and frame count
   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         cntr_in     <= '0;
         seq_err_cnt <= '0;
         seq_expect  <= '0;
      end else if (cntr_clr) begin
         cntr_in     <= '0;
         seq_err_cnt <= '0;
         seq_expect  <= '0;
      end else if (seq_beat) begin
         cntr_in    <= cntr_in + 1'b1;
         seq_expect <= link_rx_data + 1'b1;   // Resync on the received number
         if (link_rx_data != seq_expect) begin
            seq_err_cnt <= seq_err_cnt + 1'b1;
         end
      end
   end

   a_last_needs_valid: assert property (
      @(posedge usr_clk) disable iff (!S_AXI_ARESETN)
      m_rx_last |-> m_rx_valid
   );

endmodule

// ==== axil_regs.sv ====
`timescale 1ns/1ps

`include "aurora_frame_cfg.svh"

module axil_regs
   import aurora_frame_pkg::*;
(
   input  logic                  usr_clk,
   input  logic                  S_AXI_ARESETN,

   // Write address, data and response
   input  logic [`AF_ADDR_W-1:0] S_AXI_AWADDR,
   input  logic                  S_AXI_AWVALID,
   output logic                  S_AXI_AWREADY,
   input  word_t                 S_AXI_WDATA,
   input  logic                  S_AXI_WVALID,
   output logic                  S_AXI_WREADY,
   output logic                  S_AXI_BVALID,
   input  logic                  S_AXI_BREADY,

   // Read address and data
   input  logic [`AF_ADDR_W-1:0] S_AXI_ARADDR,
   input  logic                  S_AXI_ARVALID,
   output logic                  S_AXI_ARREADY,
   output word_t                 S_AXI_RDATA,
   output logic                  S_AXI_RVALID,
   input  logic                  S_AXI_RREADY,

   // Status from the stream modules
   input  cntr_t                 cntr_in,
   input  cntr_t                 cntr_out,
   input  word_t                 seq_err_cnt,

   output logic                  strip_en,
   output logic                  cntr_clr
);

   logic [`AF_ADDR_W-1:0] wr_addr;
   reg_addr_t             wr_idx;
   reg_addr_t             rd_idx;
   logic                  wr_accept;
   logic                  wr_en;
   logic                  rd_accept;
   word_t                 rd_mux;

   // One write at a time, a new one waits for the response to go
   assign wr_accept = S_AXI_AWVALID && S_AXI_WVALID && !S_AXI_AWREADY && !S_AXI_BVALID;
   assign wr_en     = S_AXI_AWVALID && S_AXI_WVALID && S_AXI_AWREADY && S_AXI_WREADY;
   assign wr_idx    = reg_addr_t'(wr_addr[`AF_ADDR_W-1:2]);

   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         S_AXI_AWREADY <= 1'b0;
         S_AXI_WREADY  <= 1'b0;
      end else begin
         S_AXI_AWREADY <= wr_accept;   // Single-cycle pulses
         S_AXI_WREADY  <= wr_accept;
      end
   end

   always_ff @(posedge usr_clk) begin
      if (wr_accept) begin
         wr_addr <= S_AXI_AWADDR;
      end
   end

   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         S_AXI_BVALID <= 1'b0;
      end else if (wr_en) begin
         S_AXI_BVALID <= 1'b1;
      end else if (S_AXI_BVALID && S_AXI_BREADY) begin
         S_AXI_BVALID <= 1'b0;
      end
   end

   // Control register
   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         strip_en <= 1'b1;
         cntr_clr <= 1'b0;
      end else begin
         cntr_clr <= 1'b0;
         if (wr_en && wr_idx == REG_CTRL) begin
            strip_en <= S_AXI_WDATA[0];
            cntr_clr <= S_AXI_WDATA[1];   // Self-clearing
         end
      end
   end

   // Read side, data captured together with the address
   assign rd_accept = S_AXI_ARVALID && !S_AXI_ARREADY && !S_AXI_RVALID;
   assign rd_idx    = reg_addr_t'(S_AXI_ARADDR[`AF_ADDR_W-1:2]);

   always_comb begin
      case (rd_idx)
         REG_STAT:       rd_mux = seq_err_cnt;
         REG_CTRL:       rd_mux = {{(`AF_DATA_W-1){1'b0}}, strip_en};
         REG_CNTR_IN_L:  rd_mux = cntr_in[`AF_DATA_W-1:0];
         REG_CNTR_IN_H:  rd_mux = cntr_in[`AF_CNTR_W-1:`AF_DATA_W];
         REG_CNTR_OUT_H: rd_mux = cntr_out[`AF_CNTR_W-1:`AF_DATA_W];
         REG_CNTR_OUT_L: rd_mux = cntr_out[`AF_DATA_W-1:0];
         default:        rd_mux = '0;   // Unmapped
      endcase
   end

   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         S_AXI_ARREADY <= 1'b0;
         S_AXI_RVALID  <= 1'b0;
      end else begin
         S_AXI_ARREADY <= rd_accept;
         if (rd_accept) begin
            S_AXI_RVALID <= 1'b1;
         end else if (S_AXI_RVALID && S_AXI_RREADY) begin
            S_AXI_RVALID <= 1'b0;
         end
      end
   end

   always_ff @(posedge usr_clk) begin
      if (rd_accept) begin
         S_AXI_RDATA <= rd_mux;
      end
   end

   // Response waits for the master
   a_bvalid_hold: assert property (
      @(posedge usr_clk) disable iff (!S_AXI_ARESETN)
      (S_AXI_BVALID && !S_AXI_BREADY) |=> S_AXI_BVALID
   );

endmodule

// ==== aurora_frame.sv ====
`timescale 1ns/1ps

`include "aurora_frame_cfg.svh"

module aurora_frame
   import aurora_frame_pkg::*;
(
   input  logic                  usr_clk,
   input  logic                  S_AXI_ARESETN,

   input  logic                  s_tx_valid,   // User transmit
   input  word_t                 s_tx_data,
   input  logic                  s_tx_last,
   output logic                  s_tx_ready,

   output logic                  link_tx_valid,   // Towards the link
   output word_t                 link_tx_data,
   output logic                  link_tx_last,
   input  logic                  link_tx_ready,

   input  logic                  link_rx_valid,   // From the link
   input  word_t                 link_rx_data,
   input  logic                  link_rx_last,

   output logic                  m_rx_valid,   // User receive
   output word_t                 m_rx_data,
   output logic                  m_rx_last,

   input  logic [`AF_ADDR_W-1:0] S_AXI_AWADDR,
   input  logic                  S_AXI_AWVALID,
   output logic                  S_AXI_AWREADY,
   input  word_t                 S_AXI_WDATA,
   input  logic                  S_AXI_WVALID,
   output logic                  S_AXI_WREADY,
   output logic                  S_AXI_BVALID,
   input  logic                  S_AXI_BREADY,
   input  logic [`AF_ADDR_W-1:0] S_AXI_ARADDR,
   input  logic                  S_AXI_ARVALID,
   output logic                  S_AXI_ARREADY,
   output word_t                 S_AXI_RDATA,
   output logic                  S_AXI_RVALID,
   input  logic                  S_AXI_RREADY
);

   cntr_t cntr_out;
   cntr_t cntr_in;
   word_t seq_err_cnt;
   logic  strip_en;
   logic  cntr_clr;

   seq_append u_seq_append (
      .usr_clk       (usr_clk),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .s_tx_valid    (s_tx_valid),
      .s_tx_data     (s_tx_data),
      .s_tx_last     (s_tx_last),
      .s_tx_ready    (s_tx_ready),
      .link_tx_valid (link_tx_valid),
      .link_tx_data  (link_tx_data),
      .link_tx_last  (link_tx_last),
      .link_tx_ready (link_tx_ready),
      .cntr_clr      (cntr_clr),
      .cntr_out      (cntr_out)
   );

   seq_strip u_seq_strip (
      .usr_clk       (usr_clk),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .link_rx_valid (link_rx_valid),
      .link_rx_data  (link_rx_data),
      .link_rx_last  (link_rx_last),
      .m_rx_valid    (m_rx_valid),
      .m_rx_data     (m_rx_data),
      .m_rx_last     (m_rx_last),
      .strip_en      (strip_en),
      .cntr_clr      (cntr_clr),
      .cntr_in       (cntr_in),
      .seq_err_cnt   (seq_err_cnt)
   );

   axil_regs u_axil_regs (
      .usr_clk       (usr_clk),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .S_AXI_AWADDR  (S_AXI_AWADDR),
      .S_AXI_AWVALID (S_AXI_AWVALID),
      .S_AXI_AWREADY (S_AXI_AWREADY),
      .S_AXI_WDATA   (S_AXI_WDATA),
      .S_AXI_WVALID  (S_AXI_WVALID),
      .S_AXI_WREADY  (S_AXI_WREADY),
      .S_AXI_BVALID  (S_AXI_BVALID),
      .S_AXI_BREADY  (S_AXI_BREADY),
      .S_AXI_ARADDR  (S_AXI_ARADDR),
      .S_AXI_ARVALID (S_AXI_ARVALID),
      .S_AXI_ARREADY (S_AXI_ARREADY),
      .S_AXI_RDATA   (S_AXI_RDATA),
      .S_AXI_RVALID  (S_AXI_RVALID),
      .S_AXI_RREADY  (S_AXI_RREADY),
      .cntr_in       (cntr_in),
      .cntr_out      (cntr_out),
      .seq_err_cnt   (seq_err_cnt),
      .strip_en      (strip_en),
      .cntr_clr      (cntr_clr)
   );

endmodule

// ==== tb_aurora_frame.sv ====
`timescale 1ns/1ps

`include "aurora_frame_cfg.svh"

module tb_aurora_frame
   import aurora_frame_pkg::*;
();

   localparam int TIMEOUT       = 50;     // Cycles for one bus handshake
   localparam int DRAIN_TIMEOUT = 2000;   // Cycles for all queued frames

   logic                  usr_clk;
   logic                  S_AXI_ARESETN;
   logic                  s_tx_valid, s_tx_last, s_tx_ready;
   logic                  link_tx_valid, link_tx_last, link_tx_ready;
   logic                  link_rx_valid, link_rx_last;
   logic                  m_rx_valid, m_rx_last;
   word_t                 s_tx_data, link_tx_data, link_rx_data, m_rx_data;
   logic [`AF_ADDR_W-1:0] S_AXI_AWADDR, S_AXI_ARADDR;
   logic                  S_AXI_AWVALID, S_AXI_AWREADY, S_AXI_WVALID, S_AXI_WREADY;
   logic                  S_AXI_BVALID, S_AXI_BREADY, S_AXI_ARVALID, S_AXI_ARREADY;
   logic                  S_AXI_RVALID, S_AXI_RREADY;
   word_t                 S_AXI_WDATA, S_AXI_RDATA;

   logic [31:0] lcg_state  = 32'hc21d;
   int          value_errs = 0;
   int          other_errs = 0;
   logic [32:0] tx_q[$];         // User beats still to send, {last, data}
   logic [32:0] link_exp_q[$];   // Expected link transmit beats
   logic [32:0] rx_exp_q[$];     // Expected user receive beats
   logic        user_xfer   = 1'b0;
   logic        lb_valid    = 1'b0;
   logic        lb_last     = 1'b0;
   word_t       lb_data     = '0;
   logic        corrupt_seq = 1'b0;   // Damage the next looped-back sequence word

   // Reference model state
   logic        strip_model = 1'b1;
   word_t       tx_seq      = '0;
   word_t       rx_expect   = '0;
   word_t       err_model   = '0;
   cntr_t       sent_model  = '0;
   cntr_t       rcvd_model  = '0;

   aurora_frame UUT (.*);

   always #5 usr_clk = ~usr_clk;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic int rand_below(input int n);
      logic [31:0] r;
      r = lcg_next();
      return int'(r[31:16]) % n;   // Upper bits, the low ones repeat quickly
   endfunction

   task automatic report_mismatch(input string name, input logic [63:0] expected,
                                  input logic [63:0] actual);
      value_errs++;
      $display("** Error: %s expected %h actual %h at %0t", name, expected, actual, $time);
   endtask

   task automatic report_failure(input string what);
      other_errs++;
      $display("Failure at %0t: %s", $time, what);
   endtask

   // Sample the transfers of the coming edge, then drive at the falling edge
   task automatic step_cycle();
      logic [32:0] exp;
      #1;
      user_xfer = s_tx_valid && s_tx_ready;
      lb_valid  = link_tx_valid && link_tx_ready;
      if (lb_valid) begin
         if (link_exp_q.size() == 0) begin
            report_failure("link transmit beat with no frame pending");
         end else begin
            exp = link_exp_q.pop_front();
            if ({link_tx_last, link_tx_data} !== exp)
               report_mismatch("seq_append link beat", 64'(exp),
                               64'({link_tx_last, link_tx_data}));
         end
         lb_last = link_tx_last;
         lb_data = link_tx_data;
         if (corrupt_seq && link_tx_last) begin
            lb_data     = link_tx_data ^ 32'h0000_0100;
            corrupt_seq = 1'b0;
         end
      end
      @(negedge usr_clk);
      if (m_rx_valid) begin
         if (rx_exp_q.size() == 0) begin
            report_failure("user receive beat with no frame pending");
         end else begin
            exp = rx_exp_q.pop_front();
            if ({m_rx_last, m_rx_data} !== exp)
               report_mismatch("seq_strip user beat", 64'(exp), 64'({m_rx_last, m_rx_data}));
         end
      end
      link_rx_valid = lb_valid;   // Loopback, one beat per transfer
      link_rx_data  = lb_data;
      link_rx_last  = lb_last;
      if (user_xfer)
         void'(tx_q.pop_front());
      if (!s_tx_valid || user_xfer) begin   // Otherwise hold the offered beat
         if (tx_q.size() > 0 && rand_below(4) != 0) begin
            s_tx_valid = 1'b1;
            s_tx_data  = tx_q[0][31:0];
            s_tx_last  = tx_q[0][32];
         end else begin
            s_tx_valid = 1'b0;
         end
      end
      link_tx_ready = (rand_below(3) != 0);
   endtask

   task automatic reg_write(input logic [3:0] idx, input word_t data);
      int t;
      S_AXI_AWADDR  = {idx, 2'b00};
      S_AXI_AWVALID = 1'b1;
      S_AXI_WDATA   = data;
      S_AXI_WVALID  = 1'b1;
      t = 0;
      while (!(S_AXI_AWREADY && S_AXI_WREADY) && t < TIMEOUT) begin
         step_cycle();
         t++;
      end
      if (!(S_AXI_AWREADY && S_AXI_WREADY))
         report_failure("write address and data never accepted");
      step_cycle();   // Handshake edge
      S_AXI_AWVALID = 1'b0;
      S_AXI_WVALID  = 1'b0;
      t = 0;
      while (!S_AXI_BVALID && t < TIMEOUT) begin
         step_cycle();
         t++;
      end
      if (!S_AXI_BVALID)
         report_failure("no write response");
      repeat (rand_below(5)) begin
         step_cycle();
         if (!S_AXI_BVALID)
            report_failure("write response dropped before BREADY");
      end
      S_AXI_BREADY = 1'b1;
      step_cycle();
      S_AXI_BREADY = 1'b0;
      if (S_AXI_BVALID)
         report_failure("write response still valid after it was accepted");
   endtask

   task automatic reg_read(input logic [3:0] idx, output word_t data);
      int t;
      S_AXI_ARADDR  = {idx, 2'b00};
      S_AXI_ARVALID = 1'b1;
      t = 0;
      while (!S_AXI_ARREADY && t < TIMEOUT) begin
         step_cycle();
         t++;
      end
      if (!S_AXI_ARREADY)
         report_failure("read address never accepted");
      step_cycle();
      S_AXI_ARVALID = 1'b0;
      if (!S_AXI_RVALID)
         report_failure("read data not valid after the address handshake");
      data = S_AXI_RDATA;
      repeat (rand_below(5)) begin
         step_cycle();
         if (!S_AXI_RVALID || S_AXI_RDATA !== data)
            report_failure("read data not held until RREADY");
      end
      S_AXI_RREADY = 1'b1;
      step_cycle();
      S_AXI_RREADY = 1'b0;
      if (S_AXI_RVALID)
         report_failure("read data still valid after it was accepted");
   endtask

   // Queue one user frame and predict both link and user receive beats
   task automatic send_frame(input int len);
      word_t w;
      word_t seq_rx;
      for (int i = 0; i < len; i++) begin
         w = lcg_next();
         tx_q.push_back({i == len - 1, w});
         link_exp_q.push_back({1'b0, w});
         rx_exp_q.push_back({strip_model && (i == len - 1), w});
      end
      link_exp_q.push_back({1'b1, tx_seq});
      seq_rx = corrupt_seq ? (tx_seq ^ 32'h0000_0100) : tx_seq;
      if (!strip_model)
         rx_exp_q.push_back({1'b1, seq_rx});   // Sequence word kept
      if (seq_rx != rx_expect)
         err_model = err_model + 32'd1;
      rx_expect  = seq_rx + 32'd1;
      tx_seq     = tx_seq + 32'd1;
      sent_model = sent_model + 64'd1;
      rcvd_model = rcvd_model + 64'd1;
   endtask

   task automatic run_frames(input int count);
      int t;
      repeat (count) send_frame(1 + rand_below(6));
      t = 0;
      while ((tx_q.size() > 0 || link_exp_q.size() > 0 || rx_exp_q.size() > 0)
             && t < DRAIN_TIMEOUT) begin
         step_cycle();
         t++;
      end
      if (t >= DRAIN_TIMEOUT)
         report_failure("stream frames did not drain");
      repeat (3) step_cycle();   // Catch stray beats
   endtask

   task automatic check_counters(input string phase);
      word_t lo;
      word_t hi;
      reg_read(REG_CNTR_OUT_L, lo);
      reg_read(REG_CNTR_OUT_H, hi);
      if ({hi, lo} !== sent_model)
         report_mismatch({phase, " frames sent"}, sent_model, {hi, lo});
      reg_read(REG_CNTR_IN_L, lo);
      reg_read(REG_CNTR_IN_H, hi);
      if ({hi, lo} !== rcvd_model)
         report_mismatch({phase, " frames received"}, rcvd_model, {hi, lo});
      reg_read(REG_STAT, lo);
      if (lo !== err_model)
         report_mismatch({phase, " sequence errors"}, 64'(err_model), 64'(lo));
   endtask

   initial begin
      word_t rd;
      usr_clk       = 1'b0;
      S_AXI_ARESETN = 1'b0;
      s_tx_valid    = 1'b0;
      s_tx_data     = '0;
      s_tx_last     = 1'b0;
      link_tx_ready = 1'b0;
      link_rx_valid = 1'b0;
      link_rx_data  = '0;
      link_rx_last  = 1'b0;
      S_AXI_AWADDR  = '0;
      S_AXI_AWVALID = 1'b0;
      S_AXI_WDATA   = '0;
      S_AXI_WVALID  = 1'b0;
      S_AXI_BREADY  = 1'b0;
      S_AXI_ARADDR  = '0;
      S_AXI_ARVALID = 1'b0;
      S_AXI_RREADY  = 1'b0;
      repeat (8) @(negedge usr_clk);
      S_AXI_ARESETN = 1'b1;

      reg_read(REG_CTRL, rd);
      if (rd !== 32'h1)
         report_mismatch("control reset value", 64'(32'h1), 64'(rd));

      run_frames(12);   // Append and strip under random stalls
      check_counters("strip on");

      reg_write(REG_CTRL, 32'h0);
      strip_model = 1'b0;
      run_frames(5);
      check_counters("strip off");

      reg_write(REG_CTRL, 32'h1);
      strip_model = 1'b1;
      run_frames(3);

      corrupt_seq = 1'b1;   // One bad sequence word on the loopback
      run_frames(1);
      check_counters("sequence gap");
      run_frames(2);
      check_counters("after gap");

      reg_read(4'd4, rd);
      if (rd !== '0)
         report_mismatch("unmapped read", 64'(0), 64'(rd));

      reg_write(REG_CTRL, 32'h3);   // Clear, strip stays on
      sent_model = '0;
      rcvd_model = '0;
      err_model  = '0;
      rx_expect  = '0;
      check_counters("clear");

      $display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== aurora_frame.f ====
+incdir+.
aurora_frame_pkg.sv
seq_append.sv
seq_strip.sv
axil_regs.sv
aurora_frame.sv
tb_aurora_frame.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_aurora_frame -f aurora_frame.f

sim_out="$(./obj_dir/Vtb_aurora_frame)"
echo "$sim_out"

if grep -qx "Testbench passed" <<< "$sim_out"; then
   exit 0
fi
exit 1
